// ==== hw/simd_pkg.sv ====
// SIMD execution unit package
// Operation and element-width encodings, lane and vector data types,
// the decoded instruction format and the FIFO sizing constants

package simd_pkg;

    localparam int NUM_LANES  = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;  // log2 of FIFO_DEPTH

    typedef enum logic [3:0] {
        VADD  = 4'd0,
        VSUB  = 4'd1,
        VMIN  = 4'd2,
        VMINU = 4'd3,
        VMAX  = 4'd4,
        VMAXU = 4'd5,
        VMSEQ = 4'd6,
        VAND  = 4'd7,
        VOR   = 4'd8,
        VXOR  = 4'd9,
        VSLL  = 4'd10,
        VSRL  = 4'd11,
        VSRA  = 4'd12,
        VID   = 4'd13,
        VMV   = 4'd14
    } instr_type_e;

    // Encoding is log2(SEW/8), the lanes index by it
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    typedef logic [63:0]  bus64_t;   // One lane
    typedef logic [127:0] vreg_t;    // Lane 0 in low half
    typedef logic         fu_id_t;   // Lane index

    typedef struct packed {
        instr_type_e instr_type;
        sew_e        sew;
        vreg_t       vs1;
        vreg_t       vs2;
    } simd_instr_t;

endpackage

// ==== hw/simd_instr_if.sv ====
// Instruction handoff between the FIFO and the execution stage
// valid/instr describe the head entry, pop removes it at the clock edge

`timescale 1ns/100ps

interface simd_instr_if;
    import simd_pkg::*;

    logic        valid;  // FIFO not empty
    simd_instr_t instr;  // Head entry
    logic        pop;    // Combinational from the stage

    modport fifo_mp (
        output valid,
        output instr,
        input  pop
    );

    modport exe_mp (
        input  valid,
        input  instr,
        output pop
    );

endinterface

// ==== hw/vaddsub.sv ====
// Element-wise add and subtract on one 64-bit lane
// Built from eight byte adders, the carry between bytes is cut at
// every element boundary so results wrap modulo 2^SEW

`timescale 1ns/100ps

module vaddsub (
    input  simd_pkg::instr_type_e instr_type_i,
    input  simd_pkg::sew_e        sew_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    logic       sub;
    logic [2:0] byte_mask;  // Byte index bits inside one element
    bus64_t     operand_b;

    assign sub       = (instr_type_i == VSUB);
    assign byte_mask = ~(3'b111 << sew_i);
    assign operand_b = sub ? ~data_vs2_i : data_vs2_i;  // vs1 + ~vs2 + 1

    always_comb begin
        logic [8:0] byte_sum;
        logic       cin;
        logic       carry;
        carry     = 1'b0;
        data_vd_o = '0;
        for (int j = 0; j < 8; j++) begin
            // First byte of an element takes the subtract carry-in
            cin = ((3'(j) & byte_mask) == 3'b000) ? sub : carry;
            byte_sum = {1'b0, data_vs1_i[j*8 +: 8]} + {1'b0, operand_b[j*8 +: 8]} + 9'(cin);
            data_vd_o[j*8 +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

endmodule

// ==== hw/vcomp.sv ====
// Element-wise compare on one 64-bit lane
// Signed and unsigned min/max, plus VMSEQ giving an all-ones element
// where vs1 equals vs2

`timescale 1ns/100ps

module vcomp (
    input  simd_pkg::instr_type_e instr_type_i,
    input  simd_pkg::sew_e        sew_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    wire [3:0][63:0] res_by_sew;  // One candidate per SEW

    for (genvar g = 0; g < 4; g++) begin : gen_sew
        localparam int W = 8 << g;

        for (genvar e = 0; e < 64 / W; e++) begin : gen_elem
            logic [W-1:0] elem_a;
            logic [W-1:0] elem_b;
            logic [W-1:0] elem_r;
            logic         lt_s;
            logic         lt_u;

            assign elem_a = data_vs1_i[e*W +: W];
            assign elem_b = data_vs2_i[e*W +: W];
            assign lt_s   = ($signed(elem_a) < $signed(elem_b));
            assign lt_u   = (elem_a < elem_b);

            always_comb begin
                case (instr_type_i)
                    VMIN:    elem_r = lt_s ? elem_a : elem_b;
                    VMINU:   elem_r = lt_u ? elem_a : elem_b;
                    VMAX:    elem_r = lt_s ? elem_b : elem_a;
                    VMAXU:   elem_r = lt_u ? elem_b : elem_a;
                    VMSEQ:   elem_r = (elem_a == elem_b) ? '1 : '0;  // Mask element
                    default: elem_r = '0;
                endcase
            end

            assign res_by_sew[g][e*W +: W] = elem_r;
        end
    end

    assign data_vd_o = res_by_sew[sew_i];

endmodule

// ==== hw/vshift.sv ====
// Element-wise shifts on one 64-bit lane
// Each vs1 element moves by the low log2(SEW) bits of its vs2 element

`timescale 1ns/100ps

module vshift (
    input  simd_pkg::instr_type_e instr_type_i,
    input  simd_pkg::sew_e        sew_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    wire [3:0][63:0] res_by_sew;

    for (genvar g = 0; g < 4; g++) begin : gen_sew
        localparam int W  = 8 << g;
        localparam int SH = $clog2(W);  // Shift amount bits

        for (genvar e = 0; e < 64 / W; e++) begin : gen_elem
            logic [W-1:0]  elem_a;
            logic [SH-1:0] shamt;
            logic [W-1:0]  elem_r;

            assign elem_a = data_vs1_i[e*W +: W];
            assign shamt  = data_vs2_i[e*W +: SH];

            always_comb begin
                case (instr_type_i)
                    VSLL:    elem_r = elem_a << shamt;
                    VSRL:    elem_r = elem_a >> shamt;
                    VSRA:    elem_r = $signed(elem_a) >>> shamt;  // Sign fill
                    default: elem_r = '0;
                endcase
            end

            assign res_by_sew[g][e*W +: W] = elem_r;
        end
    end

    assign data_vd_o = res_by_sew[sew_i];

endmodule

// ==== hw/functional_unit.sv ====
// One 64-bit SIMD lane
// Runs the add/sub, compare and shift blocks side by side and picks the
// result by operation, logic ops, element index and broadcast are local

`timescale 1ns/100ps

module functional_unit (
    input  simd_pkg::fu_id_t      fu_id_i,
    input  simd_pkg::instr_type_e instr_type_i,
    input  simd_pkg::sew_e        sew_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    bus64_t          result_vaddsub;
    bus64_t          result_vcomp;
    bus64_t          result_vshift;
    wire [3:0][63:0] vid_by_sew;
    wire [3:0][63:0] vmv_by_sew;

    vaddsub i_vaddsub (
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .data_vd_o    (result_vaddsub)
    );

    vcomp i_vcomp (
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .data_vd_o    (result_vcomp)
    );

    vshift i_vshift (
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .data_vd_o    (result_vshift)
    );

    for (genvar g = 0; g < 4; g++) begin : gen_sew
        localparam int W = 8 << g;
        localparam int N = 64 / W;  // Elements per lane

        for (genvar e = 0; e < N; e++) begin : gen_elem
            // Lane 1 indices continue after lane 0
            assign vid_by_sew[g][e*W +: W] = W'(int'(fu_id_i) * N + e);
            assign vmv_by_sew[g][e*W +: W] = data_vs1_i[W-1:0];
        end
    end

    always_comb begin
        case (instr_type_i)
            VADD, VSUB:                     data_vd_o = result_vaddsub;
            VMIN, VMINU, VMAX, VMAXU, VMSEQ: data_vd_o = result_vcomp;
            VAND:                           data_vd_o = data_vs1_i & data_vs2_i;
            VOR:                            data_vd_o = data_vs1_i | data_vs2_i;
            VXOR:                           data_vd_o = data_vs1_i ^ data_vs2_i;
            VSLL, VSRL, VSRA:               data_vd_o = result_vshift;
            VID:                            data_vd_o = vid_by_sew[sew_i];
            VMV:                            data_vd_o = vmv_by_sew[sew_i];
            default:                        data_vd_o = '0;
        endcase
    end

endmodule

// ==== hw/simd_instr_fifo.sv ====
// Four-entry instruction FIFO
// Circular buffer with a push strobe on the write side and the head
// entry offered to the execution stage through simd_instr_if

`timescale 1ns/100ps

module simd_instr_fifo (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  simd_pkg::simd_instr_t instr_i,
    output logic                  full_o,
    simd_instr_if.fifo_mp         out_if
);
    import simd_pkg::*;

    simd_instr_t           mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic [FIFO_PTR_W:0]   count_next;
    logic                  push_en;
    logic                  pop_en;

    assign pop_en  = out_if.pop & out_if.valid;
    assign push_en = push_i & (~full_o | pop_en);  // Full but draining still accepts

    always_comb begin
        count_next = count;
        if (push_en && !pop_en) begin
            count_next = count + 1'b1;
        end else if (pop_en && !push_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_o <= 1'b0;
        end else begin
            if (push_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (pop_en)  rd_ptr <= rd_ptr + 1'b1;
            count  <= count_next;
            full_o <= (count_next == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_en) mem[wr_ptr] <= instr_i;
    end

    assign out_if.valid = (count != '0);
    assign out_if.instr = mem[rd_ptr];

endmodule

// ==== hw/simd_exe_stage.sv ====
// SIMD execution stage
// Pops the head instruction unless held, splits the operands over the
// lanes and registers the 128-bit result with a one-cycle valid pulse

`timescale 1ns/100ps

module simd_exe_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            hold_i,
    simd_instr_if.exe_mp    in_if,
    output logic            result_valid_o,
    output simd_pkg::vreg_t result_o
);
    import simd_pkg::*;

    vreg_t lane_result;

    assign in_if.pop = ~hold_i & in_if.valid;  // Writeback port free

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        bus64_t lane_vd;

        functional_unit i_functional_unit (
            .fu_id_i      (fu_id_t'(l)),
            .instr_type_i (in_if.instr.instr_type),
            .sew_i        (in_if.instr.sew),
            .data_vs1_i   (in_if.instr.vs1[l*64 +: 64]),
            .data_vs2_i   (in_if.instr.vs2[l*64 +: 64]),
            .data_vd_o    (lane_vd)
        );

        assign lane_result[l*64 +: 64] = lane_vd;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            result_valid_o <= in_if.pop;  // One pulse per popped entry
            if (in_if.pop) begin
                result_o <= lane_result;
            end
        end
    end

endmodule

// ==== hw/simd_exe_unit.sv ====
// SIMD execution unit top level
// Issued instructions go through a four-entry FIFO into the two-lane
// execution stage, hold_i stalls the stage to model a busy writeback

`timescale 1ns/100ps

module simd_exe_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  instr_valid_i,
    input  simd_pkg::instr_type_e instr_type_i,
    input  simd_pkg::sew_e        sew_i,
    input  simd_pkg::vreg_t       vs1_i,
    input  simd_pkg::vreg_t       vs2_i,
    input  logic                  hold_i,
    output logic                  full_o,
    output logic                  result_valid_o,
    output simd_pkg::vreg_t       result_o
);
    import simd_pkg::*;

    simd_instr_t issue_instr;

    simd_instr_if instr_if ();

    assign issue_instr = '{instr_type: instr_type_i, sew: sew_i, vs1: vs1_i, vs2: vs2_i};

    simd_instr_fifo i_simd_instr_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (instr_valid_i),
        .instr_i (issue_instr),
        .full_o  (full_o),
        .out_if  (instr_if.fifo_mp)
    );

    simd_exe_stage i_simd_exe_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hold_i         (hold_i),
        .in_if          (instr_if.exe_mp),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

// ==== verification/simd_exe_sva.sv ====
// Assertions for the SIMD execution unit
// Stall behavior, the FIFO head handshake and the state after reset

`timescale 1ns/100ps

module simd_exe_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic hold_i,
    input logic full_i,
    input logic result_valid_i,
    input logic head_valid_i
);

    // A held stage pops nothing, so no result follows
    no_result_after_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) hold_i |=> !result_valid_i
    ) else $error("result_valid_o high after a held cycle");

    // Full level and head valid come from separate state
    full_has_head: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) full_i |-> head_valid_i
    ) else $error("FIFO full without a valid head entry");

    outputs_low_after_reset: assert property (
        @(posedge clk_i) !rst_n_i |=> (!result_valid_i && !full_i)
    ) else $error("Control outputs not low after reset");

endmodule

// ==== verification/simd_exe_tb.sv ====
// Directed testbench for the SIMD execution unit
// Drives each operation at every SEW, predicts results from the element rules
// and checks latency, stalls, FIFO full and result order

`timescale 1ns/100ps

module simd_exe_tb;
    import simd_pkg::*;

    localparam int RESULT_TIMEOUT = 20;  // Cycles

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    instr_type_e instr_type_i;
    sew_e        sew_i;
    vreg_t       vs1_i;
    vreg_t       vs2_i;
    logic        hold_i;
    logic        full_o;
    logic        result_valid_o;
    vreg_t       result_o;
    logic [31:0] lfsr_state = 32'h53c7_e190;

    simd_exe_unit i_dut (.*);

    bind simd_exe_unit simd_exe_sva i_simd_exe_sva (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hold_i         (hold_i),
        .full_i         (full_o),
        .result_valid_i (result_valid_o),
        .head_valid_i   (instr_if.valid)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic next_lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;  // Galois taps
        return out;
    endfunction

    function automatic vreg_t random_vreg();
        vreg_t v;
        v = '0;
        for (int i = 0; i < 128; i++) begin
            v = {v[126:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    // Element rules; signed order is unsigned order with the sign bit flipped
    function automatic vreg_t expected_result(instr_type_e op, sew_e sew, vreg_t a, vreg_t b);
        int          w;
        logic [63:0] mask;
        logic [63:0] msb;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] sh;
        logic [63:0] er;
        vreg_t       res;
        w    = 8 << int'(sew);
        mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        msb  = 64'd1 << (w - 1);
        res  = '0;
        for (int i = 0; i < 128 / w; i++) begin
            ea = 64'(a >> (i * w)) & mask;
            eb = 64'(b >> (i * w)) & mask;
            sh = eb & 64'(w - 1);
            case (op)
                VADD:    er = ea + eb;
                VSUB:    er = ea - eb;
                VMIN:    er = ((ea ^ msb) < (eb ^ msb)) ? ea : eb;
                VMINU:   er = (ea < eb) ? ea : eb;
                VMAX:    er = ((ea ^ msb) < (eb ^ msb)) ? eb : ea;
                VMAXU:   er = (ea < eb) ? eb : ea;
                VMSEQ:   er = (ea == eb) ? mask : '0;
                VAND:    er = ea & eb;
                VOR:     er = ea | eb;
                VXOR:    er = ea ^ eb;
                VSLL:    er = ea << sh;
                VSRL:    er = ea >> sh;
                VSRA:    er = (ea >> sh) | (((ea & msb) != '0) ? ~(mask >> sh) : '0);
                VID:     er = 64'(i);  // Global index, lane 1 continues
                VMV:     er = 64'(a >> (((i * w) / 64) * 64));  // Own lane's element 0
                default: er = '0;
            endcase
            res |= vreg_t'(er & mask) << (i * w);
        end
        return res;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_result(string name, vreg_t got, vreg_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic drive_instr(instr_type_e op, sew_e sew, vreg_t a, vreg_t b);
        instr_valid_i = 1'b1;
        instr_type_i  = op;
        sew_i         = sew;
        vs1_i         = a;
        vs2_i         = b;
    endtask

    // Returns at 1 ns after the edge where result_valid_o is seen
    task automatic wait_for_result(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (!result_valid_o && cycles >= RESULT_TIMEOUT) begin
                stop_on_error("Timed out waiting for result_valid_o");
            end
        end while (!result_valid_o);
    endtask

    task automatic run_op(instr_type_e op, sew_e sew, vreg_t a, vreg_t b);
        int cycles;
        drive_instr(op, sew, a, b);
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
        wait_for_result(cycles);
        if (cycles != 1) begin
            stop_on_error($sformatf("Result came %0d cycles after strobe", cycles + 1));
        end
        check_result("result_o", result_o, expected_result(op, sew, a, b));
        @(posedge clk_i);
        #1;
        check_flag("result_valid_o", result_valid_o, 1'b0);  // Single-cycle pulse
        #1;
    endtask

    task automatic reset_values();
        check_flag("result_valid_o", result_valid_o, 1'b0);
        check_flag("full_o", full_o, 1'b0);
        check_result("result_o", result_o, '0);
    endtask

    task automatic arithmetic_ops();
        for (int s = 0; s < 4; s++) begin
            run_op(VADD, sew_e'(s), random_vreg(), random_vreg());
            run_op(VSUB, sew_e'(s), random_vreg(), random_vreg());
            run_op(VADD, sew_e'(s), '1, {16{8'h01}});   // Every element wraps
            run_op(VSUB, sew_e'(s), '0, random_vreg());  // Borrow out of each element
        end
    endtask

    task automatic compare_ops();
        vreg_t a;
        vreg_t b;
        for (int s = 0; s < 4; s++) begin
            for (int k = int'(VMIN); k <= int'(VMSEQ); k++) begin
                a = random_vreg();
                b = random_vreg();
                if (s == 3) b[127:64] = a[127:64];
                else        b[127:96] = a[127:96];
                a[63] = 1'b1;  // Signed and unsigned order disagree here
                b[63] = 1'b0;
                run_op(instr_type_e'(k), sew_e'(s), a, b);
            end
        end
    endtask

    task automatic logic_and_shift_ops();
        for (int s = 0; s < 4; s++) begin
            for (int k = int'(VAND); k <= int'(VSRA); k++) begin
                run_op(instr_type_e'(k), sew_e'(s), random_vreg(), random_vreg());
            end
        end
    endtask

    task automatic index_and_broadcast();
        for (int s = 0; s < 4; s++) begin
            run_op(VID, sew_e'(s), random_vreg(), random_vreg());
            run_op(VMV, sew_e'(s), random_vreg(), random_vreg());
        end
    endtask

    task automatic backpressure_order();
        vreg_t expected_q [$];
        vreg_t a;
        vreg_t b;
        int    cycles;
        hold_i = 1'b1;
        for (int n = 0; n < FIFO_DEPTH; n++) begin
            a = random_vreg();
            b = random_vreg();
            expected_q.push_back(expected_result(instr_type_e'(n), sew_e'(n), a, b));
            drive_instr(instr_type_e'(n), sew_e'(n), a, b);
            @(posedge clk_i);
            #1;
            check_flag("result_valid_o", result_valid_o, 1'b0);  // Nothing leaves while held
            #1;
        end
        instr_valid_i = 1'b0;
        check_flag("full_o", full_o, 1'b1);
        hold_i = 1'b0;
        while (expected_q.size() > 0) begin
            wait_for_result(cycles);
            if (cycles != 1) stop_on_error("Queued results did not leave back to back");
            check_result("result_o", result_o, expected_q.pop_front());
        end
        #1;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_type_i  = VADD;
        sew_i         = SEW_8;
        vs1_i         = '0;
        vs2_i         = '0;
        hold_i        = 1'b0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        reset_values();
        arithmetic_ops();
        compare_ops();
        logic_and_shift_ops();
        index_and_broadcast();
        backpressure_order();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/simd_pkg.sv
hw/simd_instr_if.sv
hw/vaddsub.sv
hw/vcomp.sv
hw/vshift.sv
hw/functional_unit.sv
hw/simd_instr_fifo.sv
hw/simd_exe_stage.sv
hw/simd_exe_unit.sv
verification/simd_exe_sva.sv
verification/simd_exe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SIMD execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module simd_exe_tb -o simd_exe_sim

output=$(./obj_dir/simd_exe_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
else
    exit 1
fi
